// ==== hdl/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

  // wishbone bus widths
  localparam int wb_dw = 32;
  localparam int wb_aw = 32;

  // offset bits inside one 4 KiB region
  localparam int region_bits = 12;

  // region bases, only the bits above region_bits are compared
  localparam logic [wb_aw-1:0] clint_base = 32'h2000_0000;
  localparam logic [wb_aw-1:0] ram_base = 32'h2000_1000;

  // interruptor register offsets
  // msip word, only bit 0 is implemented
  localparam logic [region_bits-1:0] msip_off = 12'h000;
  // mtimecmp low word, high word follows at +4
  localparam logic [region_bits-1:0] mtimecmp_off = 12'hC00;
  // mtime low word, high word follows at +4
  localparam logic [region_bits-1:0] mtime_off = 12'hC08;

  // compare value after reset
  // all ones keeps mtip low until software programs it
  localparam logic [63:0] mtimecmp_rst = 64'hFFFF_FFFF_FFFF_FFFF;

endpackage

`default_nettype wire

// ==== hdl/wb_periph_decode.sv ====
`default_nettype none

module wb_periph_decode #(
  parameter int unsigned ram_words = 64
) (
  input  wire logic                               wb_cyc_i,
  input  wire logic                               wb_stb_i,
  input  wire logic [periph_pkg::wb_aw-1:0]       wb_adr_i,
  input  wire logic [periph_pkg::wb_dw-1:0]       wb_dat_i,
  input  wire logic                               wb_we_i,
  input  wire logic [periph_pkg::wb_dw-1:0]       clint_rdata_i,
  input  wire logic [periph_pkg::wb_dw-1:0]       ram_rdata_i,
  output logic                                    clint_sel_o,
  output logic                                    ram_sel_o,
  output logic      [periph_pkg::region_bits-1:0] offset_o,
  output logic                                    we_o,
  output logic      [periph_pkg::wb_dw-1:0]       wdata_o,
  output logic      [periph_pkg::wb_dw-1:0]       wb_dat_o,
  output logic                                    wb_ack_o
);

  import periph_pkg::*;

  logic req;
  logic clint_hit;
  logic ram_region;
  logic ram_in_range;
  logic ram_hit;

  // a transfer happens in every cycle with cyc and stb high
  assign req = wb_cyc_i & wb_stb_i;
  // zero wait state, ack even for unmapped addresses
  assign wb_ack_o = req;

  // region match on the upper address bits
  assign clint_hit = (wb_adr_i[wb_aw-1:region_bits] == clint_base[wb_aw-1:region_bits]);
  assign ram_region = (wb_adr_i[wb_aw-1:region_bits] == ram_base[wb_aw-1:region_bits]);
  // word index must fall inside the implemented depth
  assign ram_in_range = (32'(wb_adr_i[region_bits-1:2]) < ram_words);
  assign ram_hit = ram_region & ram_in_range;

  // one-cycle access strobes, at most one is high
  assign clint_sel_o = req & clint_hit;
  assign ram_sel_o = req & ram_hit;

  // shared to both targets
  assign offset_o = wb_adr_i[region_bits-1:0];
  assign we_o = wb_we_i;
  assign wdata_o = wb_dat_i;

  // read data mux
  // zero on writes, idle cycles and unmapped addresses
  always_comb begin
    wb_dat_o = '0;
    if (req && !wb_we_i) begin
      if (clint_hit) begin
        wb_dat_o = clint_rdata_i;
      end else if (ram_hit) begin
        wb_dat_o = ram_rdata_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/clint.sv ====
`default_nettype none

module clint (
  input  wire logic                               wb_clk_i,
  input  wire logic                               wb_rst_i,
  input  wire logic                               sel_i,
  input  wire logic                               we_i,
  input  wire logic [periph_pkg::region_bits-1:0] offset_i,
  input  wire logic [periph_pkg::wb_dw-1:0]       wdata_i,
  output logic      [periph_pkg::wb_dw-1:0]       rdata_o,
  output logic                                    mtip_o,
  output logic                                    msip_o
);

  import periph_pkg::*;

  // high halves sit one word above the low halves
  localparam logic [region_bits-1:0] mtimecmp_hi_off = mtimecmp_off + 12'd4;
  localparam logic [region_bits-1:0] mtime_hi_off = mtime_off + 12'd4;

  logic [2*wb_dw-1:0] mtime;
  logic [2*wb_dw-1:0] mtimecmp;
  logic               msip;

  logic wr;
  logic wr_msip;
  logic wr_cmp_lo;
  logic wr_cmp_hi;
  logic wr_mtime_lo;
  logic wr_mtime_hi;

  // write strobes per register half
  assign wr = sel_i & we_i;
  assign wr_msip = wr && (offset_i == msip_off);
  assign wr_cmp_lo = wr && (offset_i == mtimecmp_off);
  assign wr_cmp_hi = wr && (offset_i == mtimecmp_hi_off);
  assign wr_mtime_lo = wr && (offset_i == mtime_off);
  assign wr_mtime_hi = wr && (offset_i == mtime_hi_off);

  // free running timer
  // a write to one half loads it and holds the other half for that edge
  // writes elsewhere do not stall the count
  always_ff @(posedge wb_clk_i, posedge wb_rst_i) begin
    if (wb_rst_i) begin
      mtime <= '0;
    end else if (wr_mtime_lo) begin
      mtime[wb_dw-1:0] <= wdata_i;
    end else if (wr_mtime_hi) begin
      mtime[2*wb_dw-1:wb_dw] <= wdata_i;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // compare register, written in 32 bit halves
  always_ff @(posedge wb_clk_i, posedge wb_rst_i) begin
    if (wb_rst_i) begin
      mtimecmp <= mtimecmp_rst;
    end else if (wr_cmp_lo) begin
      mtimecmp[wb_dw-1:0] <= wdata_i;
    end else if (wr_cmp_hi) begin
      mtimecmp[2*wb_dw-1:wb_dw] <= wdata_i;
    end
  end

  // software interrupt, only bit 0 of the bus word is kept
  always_ff @(posedge wb_clk_i, posedge wb_rst_i) begin
    if (wb_rst_i) begin
      msip <= 1'b0;
    end else if (wr_msip) begin
      msip <= wdata_i[0];
    end
  end

  assign msip_o = msip;

  // unsigned 64 bit compare, combinational from the registers
  assign mtip_o = (mtime >= mtimecmp);

  // register read, the decoder gates it with the request
  always_comb begin
    case (offset_i)
      msip_off:        rdata_o = {{(wb_dw-1){1'b0}}, msip};
      mtimecmp_off:    rdata_o = mtimecmp[wb_dw-1:0];
      mtimecmp_hi_off: rdata_o = mtimecmp[2*wb_dw-1:wb_dw];
      mtime_off:       rdata_o = mtime[wb_dw-1:0];
      mtime_hi_off:    rdata_o = mtime[2*wb_dw-1:wb_dw];
      // unknown offsets read as zero
      default:         rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/scratch_ram.sv ====
`default_nettype none

module scratch_ram #(
  parameter int unsigned ram_words = 64
) (
  input  wire logic                               wb_clk_i,
  input  wire logic                               sel_i,
  input  wire logic                               we_i,
  input  wire logic [periph_pkg::region_bits-1:0] offset_i,
  input  wire logic [periph_pkg::wb_dw-1:0]       wdata_i,
  output logic      [periph_pkg::wb_dw-1:0]       rdata_o
);

  import periph_pkg::*;

  // word index width, depth is a power of two up to 1024
  localparam int idx_w = $clog2(ram_words);

  // storage, no reset so contents start undefined
  logic [wb_dw-1:0] mem [ram_words];

  logic [idx_w-1:0] idx;
  logic             wr;

  // byte offset to word index
  // the decoder already rejects words past the depth
  assign idx = offset_i[idx_w+1:2];

  assign wr = sel_i & we_i;

  // write on the edge that ends the cycle
  always_ff @(posedge wb_clk_i) begin
    if (wr) begin
      mem[idx] <= wdata_i;
    end
  end

  // asynchronous read port
  // decoder masks it outside a ram read
  assign rdata_o = mem[idx];

endmodule

`default_nettype wire

// ==== hdl/periph_top.sv ====
`default_nettype none

module periph_top #(
  parameter int unsigned ram_words = 64
) (
  input  wire logic                         wb_clk_i,
  input  wire logic                         wb_rst_i,
  input  wire logic                         wb_cyc_i,
  input  wire logic                         wb_stb_i,
  input  wire logic                         wb_we_i,
  input  wire logic [periph_pkg::wb_aw-1:0] wb_adr_i,
  input  wire logic [periph_pkg::wb_dw-1:0] wb_dat_i,
  output logic      [periph_pkg::wb_dw-1:0] wb_dat_o,
  output logic                              wb_ack_o,
  output logic                              mtip_o,
  output logic                              msip_o
);

  import periph_pkg::*;

  // per target strobes
  logic clint_sel;
  logic ram_sel;

  // shared request fields
  logic [region_bits-1:0] offset;
  logic                   we;
  logic [wb_dw-1:0]       wdata;

  // target read words back to the mux
  logic [wb_dw-1:0] clint_rdata;
  logic [wb_dw-1:0] ram_rdata;

  wb_periph_decode #(
    .ram_words(ram_words)
  ) u_decode (
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_we_i      (wb_we_i),
    .clint_rdata_i(clint_rdata),
    .ram_rdata_i  (ram_rdata),
    .clint_sel_o  (clint_sel),
    .ram_sel_o    (ram_sel),
    .offset_o     (offset),
    .we_o         (we),
    .wdata_o      (wdata),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o)
  );

  // timer and software interrupt block
  clint u_clint (
    .wb_clk_i(wb_clk_i),
    .wb_rst_i(wb_rst_i),
    .sel_i   (clint_sel),
    .we_i    (we),
    .offset_i(offset),
    .wdata_i (wdata),
    .rdata_o (clint_rdata),
    .mtip_o  (mtip_o),
    .msip_o  (msip_o)
  );

  // scratch memory, same depth the decoder checks against
  scratch_ram #(
    .ram_words(ram_words)
  ) u_ram (
    .wb_clk_i(wb_clk_i),
    .sel_i   (ram_sel),
    .we_i    (we),
    .offset_i(offset),
    .wdata_i (wdata),
    .rdata_o (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== verification/periph_chk.sv ====
`default_nettype none

module periph_chk (
  input wire logic                         wb_clk_i,
  input wire logic                         wb_rst_i,
  input wire logic                         wb_cyc_i,
  input wire logic                         wb_stb_i,
  input wire logic                         wb_we_i,
  input wire logic                         ack_i,
  input wire logic [periph_pkg::wb_dw-1:0] dat_i,
  input wire logic                         msip_i
);

  // zero wait state, ack is the request itself
  ack_follows_req: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i == (wb_cyc_i && wb_stb_i)
  ) else $error("ack differs from cyc and stb");

  // software interrupt clear right after reset
  msip_low_after_reset: assert property (
    @(posedge wb_clk_i)
    $fell(wb_rst_i) |-> !msip_i
  ) else $error("msip set in the first cycle after reset");

  // read bus idles at zero
  dat_zero_no_read: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wb_cyc_i && wb_stb_i && !wb_we_i) |-> dat_i == '0
  ) else $error("read data nonzero outside a read");

endmodule

bind periph_top periph_chk u_chk (
  .wb_clk_i(wb_clk_i),
  .wb_rst_i(wb_rst_i),
  .wb_cyc_i(wb_cyc_i),
  .wb_stb_i(wb_stb_i),
  .wb_we_i (wb_we_i),
  .ack_i   (wb_ack_o),
  .dat_i   (wb_dat_o),
  .msip_i  (msip_o)
);

`default_nettype wire

// ==== verification/periph_tb.sv ====
`default_nettype none

module periph_tb;

  localparam int clk_period = 4;
  localparam int ram_words = 64;

  // test lengths
  localparam int n_time_rd = 16;
  localparam int n_cmp = 24;
  localparam int n_msip = 8;
  localparam int n_ram = 200;
  localparam int n_unmapped = 60;
  // worst case bus cycles, idle gaps included
  localparam int max_cycles = 11 + n_time_rd * 9 + n_cmp * 9 + n_msip * 2 + n_ram * 2
                              + n_unmapped * 2 + ram_words;

  localparam logic [31:0] clint_base = 32'h2000_0000;
  localparam logic [31:0] ram_base = 32'h2000_1000;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        mtip_o;
  logic        msip_o;

  // reference model state
  logic [63:0] sh_mtime;
  logic [63:0] sh_cmp;
  logic        sh_msip;
  logic [31:0] ram_model [int];

  logic [31:0] rd;
  logic [31:0] adr;
  logic [31:0] dat;
  int          word;

  periph_top #(
    .ram_words(ram_words)
  ) u_dut (
    .wb_clk_i(wb_clk_i),
    .wb_rst_i(wb_rst_i),
    .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i),
    .wb_we_i (wb_we_i),
    .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i),
    .wb_dat_o(wb_dat_o),
    .wb_ack_o(wb_ack_o),
    .mtip_o  (mtip_o),
    .msip_o  (msip_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #(clk_period / 2) wb_clk_i = ~wb_clk_i;
  end

  // watchdog
  initial begin
    #((max_cycles + 100) * clk_period);
    $display("Timeout: the bus tests did not complete in the allowed time");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  // expected read word, returns 0 for a ram word never written
  function automatic logic model_read(input logic [31:0] a, output logic [31:0] val);
    int w;
    w = {22'b0, a[11:2]};
    val = '0;
    model_read = 1'b1;
    if (a[31:12] == clint_base[31:12]) begin
      case (a[11:0])
        12'h000: val = {31'b0, sh_msip};
        12'hC00: val = sh_cmp[31:0];
        12'hC04: val = sh_cmp[63:32];
        12'hC08: val = sh_mtime[31:0];
        12'hC0C: val = sh_mtime[63:32];
        default: val = '0;
      endcase
    end else if (a[31:12] == ram_base[31:12] && w < ram_words) begin
      if (ram_model.exists(w)) val = ram_model[w];
      else model_read = 1'b0;
    end
  endfunction

  // model update at the edge that ends a bus cycle
  task automatic apply_edge(input logic cyc, input logic we, input logic [31:0] a,
                            input logic [31:0] d);
    logic mtime_wr;
    int   w;
    mtime_wr = 1'b0;
    w = {22'b0, a[11:2]};
    if (cyc && we) begin
      if (a[31:12] == clint_base[31:12]) begin
        case (a[11:0])
          12'h000: sh_msip = d[0];
          12'hC00: sh_cmp[31:0] = d;
          12'hC04: sh_cmp[63:32] = d;
          12'hC08: begin
            sh_mtime[31:0] = d;
            mtime_wr = 1'b1;
          end
          12'hC0C: begin
            sh_mtime[63:32] = d;
            mtime_wr = 1'b1;
          end
          default: ;
        endcase
      end else if (a[31:12] == ram_base[31:12] && w < ram_words) begin
        ram_model[w] = d;
      end
    end
    // counter runs on every edge except an mtime write
    if (!mtime_wr) sh_mtime = sh_mtime + 64'd1;
  endtask

  // one bus cycle, entered 1 unit after a rising edge
  task automatic bus_cycle(input logic cyc, input logic we, input logic [31:0] a,
                           input logic [31:0] d, output logic [31:0] rdata);
    logic [31:0] exp_rd;
    logic        known;
    wb_cyc_i = cyc;
    wb_stb_i = cyc;
    wb_we_i = we;
    wb_adr_i = a;
    wb_dat_i = d;
    // sample just before the next edge
    #2;
    check_val("wb_ack_o", 32'(cyc), 32'(wb_ack_o));
    check_val("mtip_o", 32'(sh_mtime >= sh_cmp), 32'(mtip_o));
    check_val("msip_o", 32'(sh_msip), 32'(msip_o));
    rdata = wb_dat_o;
    if (cyc && !we) begin
      known = model_read(a, exp_rd);
      if (known) check_val("wb_dat_o", exp_rd, wb_dat_o);
    end else begin
      check_val("wb_dat_o", 32'h0, wb_dat_o);
    end
    @(posedge wb_clk_i);
    apply_edge(cyc, we, a, d);
    #1;
  endtask

  task automatic read_word(input logic [31:0] a, output logic [31:0] rdata);
    bus_cycle(1'b1, 1'b0, a, 32'h0, rdata);
  endtask

  task automatic write_word(input logic [31:0] a, input logic [31:0] d);
    logic [31:0] dummy;
    bus_cycle(1'b1, 1'b1, a, d, dummy);
  endtask

  task automatic idle_cycles(input int n);
    logic [31:0] dummy;
    for (int k = 0; k < n; k++) bus_cycle(1'b0, 1'b0, 32'h0, 32'h0, dummy);
  endtask

  initial begin
    void'($urandom(26190));
    wb_rst_i = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    sh_mtime = '0;
    sh_cmp = 64'hFFFF_FFFF_FFFF_FFFF;
    sh_msip = 1'b0;
    repeat (2) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;

    // reset state, compare register all ones
    idle_cycles(1);
    read_word(clint_base + 32'hC00, rd);
    check_val("mtimecmp_lo", 32'hFFFF_FFFF, rd);
    read_word(clint_base + 32'hC04, rd);
    check_val("mtimecmp_hi", 32'hFFFF_FFFF, rd);

    // free running counter at random gaps
    for (int i = 0; i < n_time_rd; i++) begin
      idle_cycles($urandom_range(7, 0));
      read_word(clint_base + 32'hC08, rd);
      read_word(clint_base + 32'hC0C, rd);
    end

    // compare and counter writes
    for (int i = 0; i < n_cmp; i++) begin
      case ($urandom_range(3, 0))
        0: write_word(clint_base + ($urandom_range(1, 0) == 1 ? 32'hC04 : 32'hC00), $urandom);
        1: write_word(clint_base + ($urandom_range(1, 0) == 1 ? 32'hC0C : 32'hC08), $urandom);
        // compare set a few ticks around the counter
        2: begin
          write_word(clint_base + 32'hC04, sh_mtime[63:32]);
          write_word(clint_base + 32'hC00, sh_mtime[31:0] + 32'($urandom_range(12, 0)) - 32'd4);
        end
        default: begin
          write_word(clint_base + 32'hC0C, sh_cmp[63:32]);
          write_word(clint_base + 32'hC08, sh_cmp[31:0] - 32'($urandom_range(8, 0)) + 32'd2);
        end
      endcase
      idle_cycles($urandom_range(6, 0));
    end

    // software interrupt, bit 0 toggles
    for (int i = 0; i < n_msip; i++) begin
      dat = $urandom;
      dat[0] = i[0];
      write_word(clint_base, dat);
      read_word(clint_base, rd);
    end

    // scratch ram traffic
    for (int i = 0; i < n_ram; i++) begin
      word = $urandom_range(ram_words - 1, 0);
      adr = ram_base + 32'(word) * 4;
      if (!ram_model.exists(word) || $urandom_range(1, 0) == 0) write_word(adr, $urandom);
      else read_word(adr, rd);
      if ($urandom_range(3, 0) == 0) idle_cycles(1);
    end

    // unmapped space acks, reads zero, ignores writes
    for (int i = 0; i < n_unmapped; i++) begin
      case ($urandom_range(2, 0))
        0: begin
          do adr = $urandom;
          while (adr[31:12] == clint_base[31:12] || adr[31:12] == ram_base[31:12]);
        end
        1: adr = ram_base + 32'($urandom_range(1023, ram_words)) * 4;
        default: begin
          do adr = clint_base + 32'($urandom_range(4095, 0));
          while (adr[11:0] inside {12'h000, 12'hC00, 12'hC04, 12'hC08, 12'hC0C});
        end
      endcase
      write_word(adr, $urandom);
      read_word(adr, rd);
      check_val("unmapped_rd", 32'h0, rd);
    end

    // interruptor registers survive the unmapped writes
    read_word(clint_base, rd);
    read_word(clint_base + 32'hC00, rd);
    read_word(clint_base + 32'hC04, rd);
    read_word(clint_base + 32'hC08, rd);
    read_word(clint_base + 32'hC0C, rd);

    // ram contents survive the unmapped writes
    foreach (ram_model[k]) read_word(ram_base + 32'(k) * 4, rd);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/periph_pkg.sv
hdl/wb_periph_decode.sv
hdl/clint.sv
hdl/scratch_ram.sv
hdl/periph_top.sv
verification/periph_chk.sv
verification/periph_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the periph_top testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module periph_tb -Mdir obj_dir -o periph_sim -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/periph_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "Finished with no errors"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
